/* verification/afe_tb.sv */
// Random testbench for the analog data path top.
// A cycle model predicts every registered output from the data path rules,
// and the trigger outputs in the same cycle. Stimulus comes from $urandom
// with a fixed seed. The run stops at the first mismatch.

module afe_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import afe_pkg::*;
  import afe_regs_pkg::*;

  localparam int PERIOD = 100;
  localparam int N_BUS  = 300; // random register traffic
  localparam int N_DATA = 200; // loops off
  localparam int N_LOOP = 100; // per loop setting
  localparam int N_TRIG = 20;  // cycles per daisy mode
  localparam int N_MODE = 10;
  localparam int TOTAL  = 5 + 10 + N_BUS + N_DATA + 4 * (N_LOOP + 2) + N_MODE * (N_TRIG + 1);

  logic                    adc_clk;
  logic                    adc_rstn;
  sys_addr_t               sys_addr;
  sys_data_t               sys_wdata;
  logic                    sys_wen;
  logic                    sys_ren;
  sys_data_t               sys_rdata;
  logic                    sys_ack;
  logic                    sys_err;
  adc_raw_t  [AFE_CH-1:0]  adc_raw;
  logic                    adc_raw_dv;
  adc_dat_t  [AFE_CH-1:0]  adc_dat;
  logic                    adc_dv;
  dac_dat_t  [AFE_CH-1:0]  asg_dat;
  dac_dat_t  [AFE_CH-1:0]  pid_dat;
  dac_code_t [AFE_CH-1:0]  dac_dat;
  logic                    trig_gpio, daisy_trig, trig_asg, scope_trig;
  logic                    trig_ext, trig_out;

  // model state, one copy of every register
  loop_t                   loop_m;
  daisy_mode_t             daisy_m;
  logic                    ack_m, err_m, rd_ack_m, dv_m;
  sys_data_t               rdata_m;
  adc_dat_t  [AFE_CH-1:0]  adc_dat_m, conv_m;
  dac_dat_t  [AFE_CH-1:0]  sat_m;
  dac_code_t [AFE_CH-1:0]  dac_m;

  afe_datapath_top afe_datapath_top_inst (
    .adc_clk (adc_clk), .adc_rstn (adc_rstn),
    .sys_addr_i (sys_addr), .sys_wdata_i (sys_wdata),
    .sys_wen_i (sys_wen), .sys_ren_i (sys_ren),
    .sys_rdata_o (sys_rdata), .sys_ack_o (sys_ack), .sys_err_o (sys_err),
    .adc_raw_i (adc_raw), .adc_raw_dv_i (adc_raw_dv),
    .adc_dat_o (adc_dat), .adc_dv_o (adc_dv),
    .asg_dat_i (asg_dat), .pid_dat_i (pid_dat), .dac_dat_o (dac_dat),
    .trig_gpio_i (trig_gpio), .daisy_trig_i (daisy_trig),
    .trig_asg_i (trig_asg), .scope_trig_i (scope_trig),
    .trig_ext_o (trig_ext), .trig_out_o (trig_out)
  );

  always #(PERIOD / 2) adc_clk = ~adc_clk;

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
    $display("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act);
    $display("Testbench failed");
    $fatal(1, "mismatch on %s", name);
  endtask

  task automatic check_adc(input adc_dat_t act, input adc_dat_t exp, input string name);
    if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
  endtask

  task automatic check_dac(input dac_code_t act, input dac_code_t exp, input string name);
    if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
  endtask

  task automatic check_rdata(input sys_data_t act, input sys_data_t exp, input string name);
    if (act !== exp) report_mismatch(name, exp, act);
  endtask

  task automatic check_trig(input logic act, input logic exp, input string name);
    if (act !== exp) report_mismatch(name, 32'(exp), 32'(act));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // negative slope code to two's complement, msb stays
  function automatic adc_dat_t decode_raw(input adc_raw_t raw);
    return adc_dat_t'(raw ^ 16'h7FFF);
  endfunction

  function automatic dac_dat_t clamp_sum(input dac_dat_t a, input dac_dat_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > 8191) return dac_dat_t'(8191);
    if (s < -8192) return dac_dat_t'(-8192);
    return dac_dat_t'(s);
  endfunction

  function automatic dac_code_t to_dac_code(input logic [DAC_DW-1:0] x);
    return dac_code_t'(x ^ 14'h1FFF); // bit 13 kept
  endfunction

  function automatic dac_dat_t rand_dac();
    int unsigned r;
    r = $urandom_range(0, 7);
    if (r == 0) return dac_dat_t'(8191);  // push into saturation
    if (r == 1) return dac_dat_t'(-8192);
    return dac_dat_t'($urandom);
  endfunction

  // everything the DUT registers on one edge, from the inputs it saw
  task automatic model_edge();
    loop_t                 loop_old;
    dac_dat_t [AFE_CH-1:0] sat_old;
    adc_dat_t [AFE_CH-1:0] conv_old;
    logic                  mapped;
    loop_old = loop_m;
    sat_old  = sat_m;
    conv_old = conv_m;
    if (!adc_rstn) begin
      loop_m    = '0;
      daisy_m   = '0;
      ack_m     = 0;
      err_m     = 0;
      rd_ack_m  = 0;
      dv_m      = 0;
      adc_dat_m = '0;
      conv_m    = '0;
      sat_m     = '0;
      dac_m     = {AFE_CH{14'h1FFF}};
    end else begin
      mapped = (sys_addr == REG_LOOP) || (sys_addr == REG_DAISY) || (sys_addr == REG_ID);
      ack_m    = 0;
      err_m    = 0;
      rd_ack_m = 0;
      if (sys_ren) begin
        ack_m    = mapped;
        err_m    = !mapped;
        rd_ack_m = mapped;
        if (sys_addr == REG_LOOP)  rdata_m = sys_data_t'(loop_m);
        if (sys_addr == REG_DAISY) rdata_m = sys_data_t'(daisy_m);
        if (sys_addr == REG_ID)    rdata_m = AFE_ID;
      end
      if (sys_wen) begin
        if (mapped && sys_addr != REG_ID) begin
          ack_m = 1;
          if (sys_addr == REG_LOOP)  loop_m  = sys_wdata[1:0];
          if (sys_addr == REG_DAISY) daisy_m = sys_wdata[2:0];
        end else begin
          err_m = 1; // id is read only
        end
      end
      for (int ch = 0; ch < AFE_CH; ch++) begin
        conv_m[ch]    = decode_raw(adc_raw[ch]);
        adc_dat_m[ch] = loop_old[0] ? adc_dat_t'(int'(sat_old[ch]) * (1 << LOOP_SHIFT))
                                    : conv_m[ch];
        sat_m[ch]     = clamp_sum(asg_dat[ch], pid_dat[ch]);
        dac_m[ch]     = to_dac_code(loop_old[1] ? conv_old[ch][15:2] : sat_old[ch]);
      end
      dv_m = loop_old[0] | adc_raw_dv;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one clock cycle: model, checks, new stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic run_cycle(input logic wen, input logic ren, input sys_addr_t addr,
                           input sys_data_t wdata);
    @(posedge adc_clk);
    #1; // registers settled, inputs not yet changed
    model_edge();
    check_trig(sys_ack, ack_m, "sys_ack_o");
    check_trig(sys_err, err_m, "sys_err_o");
    check_trig(adc_dv, dv_m, "adc_dv_o");
    if (rd_ack_m) check_rdata(sys_rdata, rdata_m, "sys_rdata_o");
    for (int ch = 0; ch < AFE_CH; ch++) begin
      check_adc(adc_dat[ch], adc_dat_m[ch], $sformatf("adc_dat_o[%0d]", ch));
      check_dac(dac_dat[ch], dac_m[ch], $sformatf("dac_dat_o[%0d]", ch));
    end
    sys_wen   = wen;
    sys_ren   = ren;
    sys_addr  = addr;
    sys_wdata = wdata;
    for (int ch = 0; ch < AFE_CH; ch++) begin
      adc_raw[ch] = adc_raw_t'($urandom);
      asg_dat[ch] = rand_dac();
      pid_dat[ch] = rand_dac();
    end
    adc_raw_dv = 1'($urandom);
    trig_gpio  = 1'($urandom);
    daisy_trig = 1'($urandom);
    trig_asg   = 1'($urandom);
    scope_trig = 1'($urandom);
    #1; // triggers are combinational
    check_trig(trig_ext, trig_gpio & ~(daisy_m[0] & daisy_trig), "trig_ext_o");
    check_trig(trig_out, daisy_m[2] ? trig_asg : scope_trig, "trig_out_o");
  endtask

  task automatic random_access();
    int unsigned kind;
    sys_addr_t   addr;
    kind = $urandom_range(0, 4);
    addr = (kind == 0) ? REG_LOOP : (kind == 1) ? REG_DAISY : (kind == 2) ? REG_ID
                                                                          : sys_addr_t'($urandom);
    if (kind > 2 && (addr == REG_LOOP || addr == REG_DAISY || addr == REG_ID))
      addr = 20'h0_000C;
    if ($urandom_range(0, 2) == 0) run_cycle(0, 0, addr, '0); // idle gap
    else if ($urandom_range(0, 1)) run_cycle(1, 0, addr, sys_data_t'($urandom));
    else run_cycle(0, 1, addr, '0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    adc_clk    = 0;
    adc_rstn   = 0;
    sys_addr   = '0;
    sys_wdata  = '0;
    sys_wen    = 0;
    sys_ren    = 0;
    adc_raw    = '0;
    adc_raw_dv = 0;
    asg_dat    = '0;
    pid_dat    = '0;
    trig_gpio  = 0;
    daisy_trig = 0;
    trig_asg   = 0;
    scope_trig = 0;
    rdata_m    = '0;
    void'($urandom(32'h9687));
    repeat (5) run_cycle(0, 0, '0, '0);
    // still holding reset values here
    check_trig(adc_dv, 1'b0, "adc_dv_o");
    check_trig(sys_ack, 1'b0, "sys_ack_o");
    check_trig(sys_err, 1'b0, "sys_err_o");
    for (int ch = 0; ch < AFE_CH; ch++) check_dac(dac_dat[ch], 14'h1FFF, "dac_dat_o");
    adc_rstn = 1;
    run_cycle(0, 1, REG_LOOP, '0);
    run_cycle(0, 1, REG_DAISY, '0);
    run_cycle(0, 1, REG_ID, '0);
    run_cycle(0, 0, '0, '0);
    repeat (N_BUS) random_access();
    run_cycle(1, 0, REG_LOOP, '0); // loops off
    repeat (N_DATA) run_cycle(0, 0, '0, '0);
    for (int l = 1; l <= 3; l++) begin
      run_cycle(1, 0, REG_LOOP, sys_data_t'(l));
      repeat (N_LOOP) run_cycle(0, 0, '0, '0);
    end
    run_cycle(1, 0, REG_LOOP, '0);
    repeat (N_LOOP) run_cycle(0, 0, '0, '0);
    repeat (N_MODE) begin
      run_cycle(1, 0, REG_DAISY, sys_data_t'($urandom));
      repeat (N_TRIG) run_cycle(0, 0, '0, '0);
    end
    run_cycle(0, 0, '0, '0);
    $display("Testbench passed");
    $finish;
  end

  // watchdog, test length plus margin
  initial begin
    #((TOTAL + 100) * PERIOD);
    $display("timeout: the test sequence did not finish in time");
    $display("Testbench failed");
    $fatal(1, "watchdog expired");
  end

endmodule : afe_tb

/* verilog/adc_decode.sv */
// ADC code decoder. Raw unsigned negative-slope codes become two's
// complement samples, registered once. adc_conv_o always carries the
// converted pin data. adc_dat_o may instead take the saturated dac samples
// (digital loop), scaled up into the adc width.

module adc_decode (
  input  logic                                     adc_clk,
  input  logic                                     adc_rstn,
  input  afe_pkg::adc_raw_t [afe_pkg::AFE_CH-1:0] adc_raw_i,   // pin codes
  input  logic                                     adc_raw_dv_i,
  input  logic                                     loop_adc_i,  // digital loop on
  input  afe_pkg::dac_dat_t [afe_pkg::AFE_CH-1:0] dac_loop_i,  // saturated dac samples
  output afe_pkg::adc_dat_t [afe_pkg::AFE_CH-1:0] adc_dat_o,
  output afe_pkg::adc_dat_t [afe_pkg::AFE_CH-1:0] adc_conv_o,  // before loop mux
  output logic                                     adc_dv_o
);

  import afe_pkg::*;

  adc_dat_t [AFE_CH-1:0] conv;   // decoded, combinational
  adc_dat_t [AFE_CH-1:0] loop;   // dac sample in adc scale
  adc_dat_t [AFE_CH-1:0] conv_r;
  adc_dat_t [AFE_CH-1:0] dat_r;
  logic                  dv_r;

  always_comb begin
    for (int ch = 0; ch < AFE_CH; ch++) begin
      // keep msb, flip the rest
      conv[ch] = {adc_raw_i[ch][ADC_DW-1], ~adc_raw_i[ch][ADC_DW-2:0]};
      // sign extend first, then scale
      loop[ch] = adc_dat_t'(dac_loop_i[ch]) <<< LOOP_SHIFT;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      conv_r <= '0;
      dat_r  <= '0;
      dv_r   <= 1'b0;
    end else begin
      conv_r <= conv;
      dat_r  <= loop_adc_i ? loop : conv;
      dv_r   <= loop_adc_i | adc_raw_dv_i; // loop data is valid every cycle
    end
  end

  assign adc_conv_o = conv_r;
  assign adc_dat_o  = dat_r;
  assign adc_dv_o   = dv_r;

endmodule : adc_decode

/* verilog/afe_ctrl.sv */
// Control registers of the analog data path plus trigger routing.
// The bus takes one-cycle wen/ren strobes. ack, or err for a bad access,
// follows one cycle later together with rdata on reads.
// The loop setting fans out to the adc decoder and the dac output stage.

module afe_ctrl (
  input  logic                    adc_clk,
  input  logic                    adc_rstn,     // sync, active low
  // register bus
  input  afe_regs_pkg::sys_addr_t sys_addr_i,
  input  afe_regs_pkg::sys_data_t sys_wdata_i,
  input  logic                    sys_wen_i,
  input  logic                    sys_ren_i,
  output afe_regs_pkg::sys_data_t sys_rdata_o,
  output logic                    sys_ack_o,
  output logic                    sys_err_o,
  // settings
  output afe_regs_pkg::loop_t     loop_cfg_o,
  // triggers
  input  logic                    trig_gpio_i,  // external pin trigger
  input  logic                    daisy_trig_i, // from daisy receiver
  input  logic                    trig_asg_i,   // generator trigger
  input  logic                    scope_trig_i, // scope trigger
  output logic                    trig_ext_o,
  output logic                    trig_out_o
);

  import afe_regs_pkg::*;

  loop_t       loop_r;
  daisy_mode_t daisy_r;
  logic        addr_hit; // address inside the map
  logic        wr_ok;
  logic        rd_ok;
  sys_data_t   rd_mux;

  ////////////////////////////////////////////////////////////////////////////
  // address decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (sys_addr_i)
      REG_LOOP, REG_DAISY, REG_ID: addr_hit = 1'b1;
      default:                     addr_hit = 1'b0;
    endcase
  end

  assign wr_ok = sys_wen_i & addr_hit & (sys_addr_i != REG_ID); // id is read only
  assign rd_ok = sys_ren_i & addr_hit;

  always_comb begin
    case (sys_addr_i)
      REG_LOOP:  rd_mux = sys_data_t'(loop_r);  // zero extended
      REG_DAISY: rd_mux = sys_data_t'(daisy_r);
      REG_ID:    rd_mux = AFE_ID;
      default:   rd_mux = '0;
    endcase
  end

  // settings, new value valid right after the write edge
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      loop_r  <= '0;
      daisy_r <= '0;
    end else if (wr_ok) begin
      if (sys_addr_i == REG_LOOP)  loop_r  <= loop_t'(sys_wdata_i);
      if (sys_addr_i == REG_DAISY) daisy_r <= daisy_mode_t'(sys_wdata_i);
    end
  end

  // bus response
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end else begin
      sys_ack_o <= wr_ok | rd_ok;
      sys_err_o <= (sys_wen_i | sys_ren_i) & ~(wr_ok | rd_ok);
    end
  end

  always_ff @(posedge adc_clk) begin
    if (sys_ren_i) sys_rdata_o <= rd_mux; // held between reads
  end

  assign loop_cfg_o = loop_r;

  ////////////////////////////////////////////////////////////////////////////
  // trigger routing
  ////////////////////////////////////////////////////////////////////////////

  // in sync mode the daisy trigger blanks the local pin
  assign trig_ext_o = trig_gpio_i & ~(daisy_r[DAISY_SYNC] & daisy_trig_i);
  assign trig_out_o = daisy_r[DAISY_TRIG_SEL] ? trig_asg_i : scope_trig_i;

  a_ack_err_excl: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
    !(sys_ack_o && sys_err_o));

endmodule : afe_ctrl

/* verilog/afe_datapath_top.sv */
// Top of the analog data path in the adc_clk domain.
// Ties the control registers, adc decoder, dac summing stage and dac
// output stage together. Samples from the generator and the controller
// enter as ports, and so do all trigger sources.

module afe_datapath_top (
  input  logic                                      adc_clk,
  input  logic                                      adc_rstn,
  // register bus
  input  afe_regs_pkg::sys_addr_t                   sys_addr_i,
  input  afe_regs_pkg::sys_data_t                   sys_wdata_i,
  input  logic                                      sys_wen_i,
  input  logic                                      sys_ren_i,
  output afe_regs_pkg::sys_data_t                   sys_rdata_o,
  output logic                                      sys_ack_o,
  output logic                                      sys_err_o,
  // adc
  input  afe_pkg::adc_raw_t  [afe_pkg::AFE_CH-1:0] adc_raw_i,
  input  logic                                      adc_raw_dv_i,
  output afe_pkg::adc_dat_t  [afe_pkg::AFE_CH-1:0] adc_dat_o,
  output logic                                      adc_dv_o,
  // dac
  input  afe_pkg::dac_dat_t  [afe_pkg::AFE_CH-1:0] asg_dat_i,
  input  afe_pkg::dac_dat_t  [afe_pkg::AFE_CH-1:0] pid_dat_i,
  output afe_pkg::dac_code_t [afe_pkg::AFE_CH-1:0] dac_dat_o,
  // triggers
  input  logic                                      trig_gpio_i,
  input  logic                                      daisy_trig_i,
  input  logic                                      trig_asg_i,
  input  logic                                      scope_trig_i,
  output logic                                      trig_ext_o,
  output logic                                      trig_out_o
);

  import afe_pkg::*;
  import afe_regs_pkg::*;

  loop_t                 loop_cfg;
  dac_dat_t [AFE_CH-1:0] dac_sat;  // to output stage and digital loop
  adc_dat_t [AFE_CH-1:0] adc_conv; // to loopback

  afe_ctrl afe_ctrl_inst (
    .adc_clk      (adc_clk),
    .adc_rstn     (adc_rstn),
    .sys_addr_i   (sys_addr_i),
    .sys_wdata_i  (sys_wdata_i),
    .sys_wen_i    (sys_wen_i),
    .sys_ren_i    (sys_ren_i),
    .sys_rdata_o  (sys_rdata_o),
    .sys_ack_o    (sys_ack_o),
    .sys_err_o    (sys_err_o),
    .loop_cfg_o   (loop_cfg),
    .trig_gpio_i  (trig_gpio_i),
    .daisy_trig_i (daisy_trig_i),
    .trig_asg_i   (trig_asg_i),
    .scope_trig_i (scope_trig_i),
    .trig_ext_o   (trig_ext_o),
    .trig_out_o   (trig_out_o)
  );

  adc_decode adc_decode_inst (
    .adc_clk      (adc_clk),
    .adc_rstn     (adc_rstn),
    .adc_raw_i    (adc_raw_i),
    .adc_raw_dv_i (adc_raw_dv_i),
    .loop_adc_i   (loop_cfg[LOOP_ADC]),
    .dac_loop_i   (dac_sat),
    .adc_dat_o    (adc_dat_o),
    .adc_conv_o   (adc_conv),
    .adc_dv_o     (adc_dv_o)
  );

  dac_sum_sat dac_sum_sat_inst (
    .adc_clk   (adc_clk),
    .adc_rstn  (adc_rstn),
    .asg_dat_i (asg_dat_i),
    .pid_dat_i (pid_dat_i),
    .dac_sat_o (dac_sat)
  );

  dac_result dac_result_inst (
    .adc_clk    (adc_clk),
    .adc_rstn   (adc_rstn),
    .dac_sat_i  (dac_sat),
    .adc_conv_i (adc_conv),
    .loop_dac_i (loop_cfg[LOOP_DAC]),
    .dac_dat_o  (dac_dat_o)
  );

endmodule : afe_datapath_top

/* verilog/afe_pkg.sv */
// Sample types and constants of the converter data path.
// Import inside a module body. Module headers use scoped names (afe_pkg::...).
// ADC codes are 16-bit, DAC codes are 14-bit. Both pin codes are unsigned
// with a negative slope, and the internal samples are two's complement.

package afe_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned AFE_CH = 2;  // channels a and b
  localparam int unsigned ADC_DW = 16; // adc sample width
  localparam int unsigned DAC_DW = 14; // dac sample width
  localparam int unsigned SUM_DW = DAC_DW + 1; // one guard bit for the sum

  ////////////////////////////////////////////////////////////////////////////
  // sample types
  ////////////////////////////////////////////////////////////////////////////

  // raw adc pin code, unsigned, negative slope
  typedef logic        [ADC_DW-1:0] adc_raw_t;
  // adc sample, two's complement
  typedef logic signed [ADC_DW-1:0] adc_dat_t;
  // dac range sample, also generator and controller outputs
  typedef logic signed [DAC_DW-1:0] dac_dat_t;
  // sum before saturation
  typedef logic signed [SUM_DW-1:0] dac_sum_t;
  // dac pin code, unsigned, negative slope
  typedef logic        [DAC_DW-1:0] dac_code_t;

  ////////////////////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////////////////////

  localparam dac_dat_t DAC_MAX = 14'sd8191;  // positive full scale
  localparam dac_dat_t DAC_MIN = -14'sd8192; // negative full scale

  // pin code of sample 0, top bit kept and the rest inverted
  localparam dac_code_t DAC_CODE_ZERO = 14'h1FFF;

  // dac sample moved into the adc width for the digital loop
  localparam int unsigned LOOP_SHIFT = ADC_DW - DAC_DW;

endpackage : afe_pkg

/* verilog/afe_regs_pkg.sv */
// Register bus types, register map and setting types of the control block.
// Import inside a module body. Module headers use scoped names.

package afe_regs_pkg;

  typedef logic [19:0] sys_addr_t; // byte address
  typedef logic [31:0] sys_data_t;

  // settings
  typedef logic [1:0] loop_t;       // [0] adc side loop, [1] dac side loopback
  typedef logic [2:0] daisy_mode_t; // [0] sync mode, [2] trigger output select

  // bit positions inside the settings
  localparam int unsigned LOOP_ADC       = 0;
  localparam int unsigned LOOP_DAC       = 1;
  localparam int unsigned DAISY_SYNC     = 0;
  localparam int unsigned DAISY_TRIG_SEL = 2;

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////

  localparam sys_addr_t REG_LOOP  = 20'h0_0000;
  localparam sys_addr_t REG_DAISY = 20'h0_0004;
  localparam sys_addr_t REG_ID    = 20'h0_0008; // read only

  localparam sys_data_t AFE_ID = 32'h4146_4501; // "AFE" + revision 1

endpackage : afe_regs_pkg

/* verilog/dac_result.sv */
// DAC output stage. Picks the saturated sample or, in loopback, the upper
// 14 bits of the converted adc sample of the same channel, then turns it
// into the unsigned negative-slope pin code and registers it.
// Output sits one cycle behind the summing stage, two behind its inputs.

module dac_result (
  input  logic                                      adc_clk,
  input  logic                                      adc_rstn,
  input  afe_pkg::dac_dat_t  [afe_pkg::AFE_CH-1:0] dac_sat_i,  // saturated sum
  input  afe_pkg::adc_dat_t  [afe_pkg::AFE_CH-1:0] adc_conv_i, // decoded adc
  input  logic                                      loop_dac_i, // loopback on
  output afe_pkg::dac_code_t [afe_pkg::AFE_CH-1:0] dac_dat_o   // pin codes
);

  import afe_pkg::*;

  dac_dat_t  [AFE_CH-1:0] sel;
  dac_code_t [AFE_CH-1:0] code;
  dac_code_t [AFE_CH-1:0] code_r;

  always_comb begin
    for (int ch = 0; ch < AFE_CH; ch++) begin
      // loopback keeps channel order, a to a and b to b
      sel[ch]  = loop_dac_i ? adc_conv_i[ch][ADC_DW-1 -: DAC_DW] : dac_sat_i[ch];
      code[ch] = {sel[ch][DAC_DW-1], ~sel[ch][DAC_DW-2:0]}; // neg slope
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pin register
  ////////////////////////////////////////////////////////////////////////////

  // reset value is the code of sample 0, not all zeros
  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      code_r <= {AFE_CH{DAC_CODE_ZERO}};
    end else begin
      code_r <= code;
    end
  end

  assign dac_dat_o = code_r;

endmodule : dac_result

/* verilog/dac_sum_sat.sv */
// DAC summing stage. Per channel the generator and controller samples are
// added with one guard bit, clamped to the 14-bit dac range and registered.
// The result feeds the dac output stage and the adc digital loop.

module dac_sum_sat (
  input  logic                                     adc_clk,
  input  logic                                     adc_rstn,
  input  afe_pkg::dac_dat_t [afe_pkg::AFE_CH-1:0] asg_dat_i, // generator
  input  afe_pkg::dac_dat_t [afe_pkg::AFE_CH-1:0] pid_dat_i, // controller
  output afe_pkg::dac_dat_t [afe_pkg::AFE_CH-1:0] dac_sat_o
);

  import afe_pkg::*;

  dac_sum_t [AFE_CH-1:0] sum;
  dac_dat_t [AFE_CH-1:0] sat;
  dac_dat_t [AFE_CH-1:0] sat_r;

  ////////////////////////////////////////////////////////////////////////////
  // sum and clamp
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int ch = 0; ch < AFE_CH; ch++) begin
      sum[ch] = dac_sum_t'(asg_dat_i[ch]) + dac_sum_t'(pid_dat_i[ch]);
      // top two bits differ -> outside the 14-bit range
      if (sum[ch][SUM_DW-1] != sum[ch][SUM_DW-2]) begin
        sat[ch] = sum[ch][SUM_DW-1] ? DAC_MIN : DAC_MAX;
      end else begin
        sat[ch] = sum[ch][DAC_DW-1:0];
      end
    end
  end

  always_ff @(posedge adc_clk) begin
    if (!adc_rstn) begin
      sat_r <= '0;
    end else begin
      sat_r <= sat;
    end
  end

  assign dac_sat_o = sat_r;

  // the guard bit must hold the full sum, else the clamp sees a wrapped value
  for (genvar ch = 0; ch < AFE_CH; ch++) begin : g_chk
    a_sum_fits: assert property (@(posedge adc_clk) disable iff (!adc_rstn)
      int'(asg_dat_i[ch]) + int'(pid_dat_i[ch]) == int'(sum[ch]));
  end

endmodule : dac_sum_sat

/* vlog.f */
verilog/afe_pkg.sv
verilog/afe_regs_pkg.sv
verilog/afe_ctrl.sv
verilog/adc_decode.sv
verilog/dac_sum_sat.sv
verilog/dac_result.sv
verilog/afe_datapath_top.sv
verification/afe_tb.sv
